//--- dac_cfg_pkg.sv
package dac_cfg_pkg;

	// register mirror seen from the processor side
	localparam int MEM_SIZE = 16;
	localparam int WORD_WIDTH = 32;

	// fresh-bit positions that start work in the controller
	localparam int RUN_PWL_ID = 0;
	localparam int PS_SEED_VALID_ID = 1;
	localparam int TRIG_WAVE_ID = 2;

	// seed words sit in consecutive registers from here on
	localparam int PS_SEED_BASE_ID = 4;

	localparam int CMD_WIDTH = 5;
	// bit 0 carries pwl_rdy, bit 1 is spare
	localparam int RESP_WIDTH = 2;

	// one-hot opcodes, all zero means the word only updates the scale
	typedef enum logic [CMD_WIDTH-1:0] {
		CMD_NONE      = 5'b00000,
		CMD_RUN_PWL   = 5'b00001,
		CMD_RUN_TRIG  = 5'b00010,
		CMD_RUN_SHIFT = 5'b00100,
		CMD_HALT      = 5'b01000,
		CMD_RESET     = 5'b10000
	} dac_cmd_e;

	typedef enum logic [2:0] {IDLE, SEND_CMD, RUN_PWL_DELAY, RST_DAC, HALT_DAC} cfg_state_e;

endpackage

//--- dac_sample_pkg.sv
package dac_sample_pkg;

	// enough bits to shift a 16-bit sample all the way down
	localparam int SCALE_WIDTH = 4;

	// galois taps for x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] LFSR_MASK = 16'hB400;

	typedef enum logic [1:0] {
		MODE_OFF,
		MODE_SHIFT,
		MODE_TRIG,
		MODE_PWL
	} gen_mode_e;

endpackage

//--- xfer_link.sv
module xfer_link #(
	parameter int DATA_WIDTH = 8
) (
	input  logic                  ps_clk,
	input  logic                  ps_rst,
	input  logic [DATA_WIDTH-1:0] data_in,
	input  logic                  valid_in,
	output logic [DATA_WIDTH-1:0] data_out,
	output logic                  valid_out,
	output logic                  rdy,
	output logic                  done
);

	logic xfer;

	// a word moves on the cycle where the source's valid meets rdy
	assign xfer = valid_in && rdy;

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			rdy <= 1'b1;
			valid_out <= 1'b0;
			done <= 1'b0;
		end else begin
			// rdy drops for the pulse cycle so the sink sees each word once
			rdy <= !xfer;
			valid_out <= xfer;
			done <= xfer;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (xfer) begin
			data_out <= data_in;
		end
	end

	a_single_pulse: assert property (@(posedge ps_clk) disable iff (ps_rst)
		valid_out |=> !valid_out)
		else $error("xfer_link valid_out held for more than one cycle");

endmodule

//--- dac_config_ctrl.sv
module dac_config_ctrl
	import dac_cfg_pkg::*, dac_sample_pkg::*;
#(
	parameter int BATCH_SAMPLES = 4,
	parameter int SAMPLE_WIDTH = 16
) (
	input  logic                                        ps_clk,
	input  logic                                        ps_rst,
	input  logic [MEM_SIZE-1:0]                         fresh_bits,
	input  logic [MEM_SIZE-1:0][WORD_WIDTH-1:0]         read_resps,
	input  logic [SCALE_WIDTH-1:0]                      scale_factor_in,
	input  logic                                        halt,
	input  logic                                        link_rdy,
	input  logic                                        link_done,
	input  logic [RESP_WIDTH-1:0]                       resp_data,
	input  logic                                        resp_valid,
	output logic [SCALE_WIDTH+BATCH_SAMPLES*SAMPLE_WIDTH+CMD_WIDTH-1:0] cmd_word,
	output logic                                        cmd_valid,
	output logic                                        cfg_ready
);

	cfg_state_e state;
	dac_cmd_e cmd_op;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] seed_set;
	logic [SCALE_WIDTH-1:0] scale_prev;
	logic scale_edge;
	logic scale_pending;
	logic pwl_rdy;
	logic can_select;
	logic sel_pwl;
	logic sel_seed;
	logic sel_trig;
	logic sel_scale;

	// the scale field follows the input level, the link samples it on transfer
	assign cmd_word = {scale_factor_in, seed_set, cmd_op};

	assign scale_edge = scale_factor_in != scale_prev;

	// a new command is only picked while nothing is waiting for the link
	assign can_select = state == IDLE && !cmd_valid && !halt;
	assign sel_pwl = can_select && fresh_bits[RUN_PWL_ID];
	assign sel_seed = can_select && !fresh_bits[RUN_PWL_ID] && fresh_bits[PS_SEED_VALID_ID];
	assign sel_trig = can_select && !fresh_bits[RUN_PWL_ID] && !fresh_bits[PS_SEED_VALID_ID]
		&& fresh_bits[TRIG_WAVE_ID];
	assign sel_scale = can_select && !fresh_bits[RUN_PWL_ID] && !fresh_bits[PS_SEED_VALID_ID]
		&& !fresh_bits[TRIG_WAVE_ID] && scale_pending;

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state <= RST_DAC;
			cmd_op <= CMD_NONE;
			cmd_valid <= 1'b0;
			cfg_ready <= 1'b0;
			seed_set <= '0;
			scale_prev <= '0;
			scale_pending <= 1'b0;
			pwl_rdy <= 1'b0;
		end else begin
			scale_prev <= scale_factor_in;
			if (resp_valid) begin
				pwl_rdy <= resp_data[0];
			end
			if (halt) begin
				// seeds and pwl_rdy survive a halt
				state <= HALT_DAC;
				cmd_op <= CMD_NONE;
				cmd_valid <= 1'b0;
				cfg_ready <= 1'b0;
			end else begin
				case (state)
					IDLE: begin
						if (cmd_valid && link_rdy) begin
							cmd_valid <= 1'b0;
							state <= SEND_CMD;
						end else if (sel_pwl) begin
							cmd_op <= CMD_RUN_PWL;
							cfg_ready <= 1'b0;
							if (pwl_rdy) begin
								// the ramp counts as busy from here until the generator says otherwise
								cmd_valid <= 1'b1;
								pwl_rdy <= 1'b0;
							end else begin
								state <= RUN_PWL_DELAY;
							end
						end else if (sel_seed) begin
							cmd_op <= CMD_RUN_SHIFT;
							for (int i = 0; i < BATCH_SAMPLES; i++) begin
								seed_set[i] <= read_resps[PS_SEED_BASE_ID+i][SAMPLE_WIDTH-1:0];
							end
							cmd_valid <= 1'b1;
							cfg_ready <= 1'b0;
						end else if (sel_trig) begin
							cmd_op <= CMD_RUN_TRIG;
							cmd_valid <= 1'b1;
							cfg_ready <= 1'b0;
						end else if (sel_scale) begin
							cmd_op <= CMD_NONE;
							cmd_valid <= 1'b1;
							cfg_ready <= 1'b0;
						end
					end
					SEND_CMD: begin
						if (link_done) begin
							cmd_op <= CMD_NONE;
							cfg_ready <= 1'b1;
							state <= IDLE;
						end
					end
					RUN_PWL_DELAY: begin
						// waits as long as the previous ramp keeps going
						if (pwl_rdy) begin
							cmd_valid <= 1'b1;
							pwl_rdy <= 1'b0;
							state <= IDLE;
						end
					end
					RST_DAC: begin
						cmd_op <= CMD_RESET;
						cmd_valid <= 1'b1;
						state <= IDLE;
					end
					HALT_DAC: begin
						cmd_op <= CMD_HALT;
						cmd_valid <= 1'b1;
						state <= IDLE;
					end
					default: state <= IDLE;
				endcase
			end
			// every sent word carries the live scale, so any selection settles a change
			if (scale_edge) begin
				scale_pending <= 1'b1;
			end else if (sel_pwl || sel_seed || sel_trig || sel_scale) begin
				scale_pending <= 1'b0;
			end
		end
	end

	a_no_valid_in_send: assert property (@(posedge ps_clk) disable iff (ps_rst)
		$rose(cmd_valid) |-> $past(state) != SEND_CMD)
		else $error("cmd_valid rose while a command was still in flight");

endmodule

//--- sample_generator.sv
module sample_generator
	import dac_cfg_pkg::*, dac_sample_pkg::*;
#(
	parameter int BATCH_SAMPLES = 4,
	parameter int SAMPLE_WIDTH = 16,
	parameter int PWL_BATCHES = 8
) (
	input  logic                                        ps_clk,
	input  logic                                        ps_rst,
	input  logic [SCALE_WIDTH+BATCH_SAMPLES*SAMPLE_WIDTH+CMD_WIDTH-1:0] cmd_word,
	input  logic                                        cmd_valid,
	input  logic                                        dac0_rdy,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0]  raw_batch,
	output logic                                        batch_valid,
	output logic [RESP_WIDTH-1:0]                       resp_data,
	output logic                                        resp_valid,
	input  logic                                        resp_rdy
);

	localparam int LFSR_WIDTH = $bits(LFSR_MASK);
	localparam int CNT_WIDTH = $clog2(PWL_BATCHES + 1);

	dac_cmd_e cmd_op;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] cmd_seeds;
	gen_mode_e mode;
	logic [BATCH_SAMPLES-1:0][LFSR_WIDTH-1:0] lfsr;
	logic [SAMPLE_WIDTH-1:0] phase;
	logic [SAMPLE_WIDTH-1:0] pwl_base;
	logic [CNT_WIDTH-1:0] pwl_count;
	logic pwl_rdy;
	logic take_cmd;
	logic step;
	logic pwl_last;

	function automatic logic [LFSR_WIDTH-1:0] lfsr_next(input logic [LFSR_WIDTH-1:0] x);
		return (x >> 1) ^ (x[0] ? LFSR_MASK : '0);
	endfunction

	// fold the top half back down and double, so the wave spans the full range
	function automatic logic [SAMPLE_WIDTH-1:0] tri_wave(input logic [SAMPLE_WIDTH-1:0] x);
		logic [SAMPLE_WIDTH-2:0] low;
		low = x[SAMPLE_WIDTH-1] ? ~x[SAMPLE_WIDTH-2:0] : x[SAMPLE_WIDTH-2:0];
		return {low, 1'b0};
	endfunction

	assign cmd_op = dac_cmd_e'(cmd_word[CMD_WIDTH-1:0]);
	assign cmd_seeds = cmd_word[CMD_WIDTH +: BATCH_SAMPLES*SAMPLE_WIDTH];

	// a scale-only word must not interrupt the running mode
	assign take_cmd = cmd_valid && cmd_op != CMD_NONE;
	assign step = !take_cmd && mode != MODE_OFF && dac0_rdy;
	assign pwl_last = mode == MODE_PWL && pwl_count == CNT_WIDTH'(PWL_BATCHES - 1);

	// the response always reports the latest status, even when it had to wait
	assign resp_data = RESP_WIDTH'(pwl_rdy);

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			mode <= MODE_OFF;
			batch_valid <= 1'b0;
			pwl_rdy <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			batch_valid <= step;
			if (resp_valid && resp_rdy) begin
				resp_valid <= 1'b0;
			end
			if (take_cmd) begin
				case (cmd_op)
					CMD_RESET, CMD_HALT: begin
						// a halted ramp is over, so the controller gets told it may start another
						mode <= MODE_OFF;
						pwl_rdy <= 1'b1;
						resp_valid <= 1'b1;
					end
					CMD_RUN_SHIFT: mode <= MODE_SHIFT;
					CMD_RUN_TRIG: mode <= MODE_TRIG;
					CMD_RUN_PWL: begin
						mode <= MODE_PWL;
						pwl_rdy <= 1'b0;
						resp_valid <= 1'b1;
					end
					default: mode <= mode;
				endcase
			end else if (step && pwl_last) begin
				mode <= MODE_OFF;
				pwl_rdy <= 1'b1;
				resp_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge ps_clk) begin
		if (take_cmd) begin
			phase <= '0;
			pwl_base <= cmd_seeds[0];
			pwl_count <= '0;
			for (int i = 0; i < BATCH_SAMPLES; i++) begin
				// an all-zero state would lock the LFSR
				lfsr[i] <= (cmd_seeds[i] == '0) ? LFSR_WIDTH'(1) : LFSR_WIDTH'(cmd_seeds[i]);
			end
		end else if (step) begin
			case (mode)
				MODE_SHIFT: begin
					for (int i = 0; i < BATCH_SAMPLES; i++) begin
						raw_batch[i] <= SAMPLE_WIDTH'(lfsr[i]);
						lfsr[i] <= lfsr_next(lfsr[i]);
					end
				end
				MODE_TRIG: begin
					for (int i = 0; i < BATCH_SAMPLES; i++) begin
						raw_batch[i] <= tri_wave(phase + SAMPLE_WIDTH'(i));
					end
					phase <= phase + SAMPLE_WIDTH'(BATCH_SAMPLES);
				end
				MODE_PWL: begin
					for (int i = 0; i < BATCH_SAMPLES; i++) begin
						raw_batch[i] <= pwl_base + SAMPLE_WIDTH'(i);
					end
					pwl_base <= pwl_base + SAMPLE_WIDTH'(BATCH_SAMPLES);
					pwl_count <= pwl_count + 1'b1;
				end
				default: raw_batch <= raw_batch;
			endcase
		end
	end

	a_batch_needs_mode: assert property (@(posedge ps_clk) disable iff (ps_rst)
		batch_valid |-> $past(mode) != MODE_OFF)
		else $error("sample_generator produced a batch while switched off");

endmodule

//--- batch_scaler.sv
module batch_scaler
	import dac_sample_pkg::*;
#(
	parameter int BATCH_SAMPLES = 4,
	parameter int SAMPLE_WIDTH = 16
) (
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic [SCALE_WIDTH-1:0]                     scale_in,
	input  logic                                       scale_load,
	input  logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] raw_batch,
	input  logic                                       raw_valid,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch,
	output logic                                       valid_dac_batch
);

	logic [SCALE_WIDTH-1:0] scale;

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			scale <= '0;
			dac_batch <= '0;
			valid_dac_batch <= 1'b0;
		end else begin
			// every command word brings a scale, even one that only starts a mode
			if (scale_load) begin
				scale <= scale_in;
			end
			valid_dac_batch <= raw_valid;
			if (raw_valid) begin
				for (int i = 0; i < BATCH_SAMPLES; i++) begin
					dac_batch[i] <= raw_batch[i] >> scale;
				end
			end
		end
	end

endmodule

//--- dac_interface.sv
module dac_interface
	import dac_cfg_pkg::*, dac_sample_pkg::*;
#(
	parameter int BATCH_SAMPLES = 4,
	parameter int SAMPLE_WIDTH = 16,
	parameter int PWL_BATCHES = 8
) (
	input  logic                                       ps_clk,
	input  logic                                       ps_rst,
	input  logic [MEM_SIZE-1:0]                        fresh_bits,
	input  logic [MEM_SIZE-1:0][WORD_WIDTH-1:0]        read_resps,
	input  logic [SCALE_WIDTH-1:0]                     scale_factor_in,
	input  logic                                       halt,
	input  logic                                       dac0_rdy,
	output logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch,
	output logic                                       valid_dac_batch,
	output logic                                       cfg_ready
);

	// command word is {scale, seeds, one-hot opcode}
	localparam int CMD_WORD_WIDTH = SCALE_WIDTH + BATCH_SAMPLES * SAMPLE_WIDTH + CMD_WIDTH;

	logic [CMD_WORD_WIDTH-1:0] cmd_word;
	logic [CMD_WORD_WIDTH-1:0] cmd_data;
	logic cmd_valid;
	logic cmd_out_valid;
	logic cmd_rdy;
	logic cmd_done;
	logic [RESP_WIDTH-1:0] gen_resp;
	logic gen_resp_valid;
	logic [RESP_WIDTH-1:0] resp_data;
	logic resp_valid;
	logic resp_rdy;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] raw_batch;
	logic raw_valid;

	dac_config_ctrl #(.BATCH_SAMPLES(BATCH_SAMPLES), .SAMPLE_WIDTH(SAMPLE_WIDTH)) u_config_ctrl (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.fresh_bits(fresh_bits), .read_resps(read_resps),
		.scale_factor_in(scale_factor_in), .halt(halt),
		.link_rdy(cmd_rdy), .link_done(cmd_done),
		.resp_data(resp_data), .resp_valid(resp_valid),
		.cmd_word(cmd_word), .cmd_valid(cmd_valid), .cfg_ready(cfg_ready));

	xfer_link #(.DATA_WIDTH(CMD_WORD_WIDTH)) cmd_link (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.data_in(cmd_word), .valid_in(cmd_valid),
		.data_out(cmd_data), .valid_out(cmd_out_valid),
		.rdy(cmd_rdy), .done(cmd_done));

	// the generator watches rdy itself, so the done pulse has no listener here
	xfer_link #(.DATA_WIDTH(RESP_WIDTH)) resp_link (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.data_in(gen_resp), .valid_in(gen_resp_valid),
		.data_out(resp_data), .valid_out(resp_valid),
		.rdy(resp_rdy), .done());

	sample_generator #(
		.BATCH_SAMPLES(BATCH_SAMPLES),
		.SAMPLE_WIDTH(SAMPLE_WIDTH),
		.PWL_BATCHES(PWL_BATCHES)
	) u_sample_generator (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.cmd_word(cmd_data), .cmd_valid(cmd_out_valid), .dac0_rdy(dac0_rdy),
		.raw_batch(raw_batch), .batch_valid(raw_valid),
		.resp_data(gen_resp), .resp_valid(gen_resp_valid), .resp_rdy(resp_rdy));

	batch_scaler #(.BATCH_SAMPLES(BATCH_SAMPLES), .SAMPLE_WIDTH(SAMPLE_WIDTH)) u_batch_scaler (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.scale_in(cmd_data[CMD_WORD_WIDTH-1 -: SCALE_WIDTH]), .scale_load(cmd_out_valid),
		.raw_batch(raw_batch), .raw_valid(raw_valid),
		.dac_batch(dac_batch), .valid_dac_batch(valid_dac_batch));

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic ps_clk,
	output logic ps_rst
);

	initial begin
		ps_clk = 1'b0;
		forever #5 ps_clk = ~ps_clk;
	end

	initial begin
		ps_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge ps_clk);
		@(negedge ps_clk);
		ps_rst = 1'b0;
	end

endmodule

//--- tb_dac_interface.sv
module tb_dac_interface
	import dac_cfg_pkg::*, dac_sample_pkg::*;
;

	localparam int BATCH_SAMPLES = 4;
	localparam int SAMPLE_WIDTH = 16;
	localparam int PWL_BATCHES = 8;
	localparam int MAX_CYCLES = 4000;

	logic ps_clk;
	logic ps_rst;
	logic [MEM_SIZE-1:0] fresh_bits;
	logic [MEM_SIZE-1:0][WORD_WIDTH-1:0] read_resps;
	logic [SCALE_WIDTH-1:0] scale_factor_in;
	logic halt;
	logic dac0_rdy;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_batch;
	logic valid_dac_batch;
	logic cfg_ready;

	// model mode is 0 for off, 1 noise, 2 triangle and 3 ramp
	int m_mode;
	logic [15:0] m_lfsr [BATCH_SAMPLES];
	logic [SAMPLE_WIDTH-1:0] m_phase;
	logic [SAMPLE_WIDTH-1:0] m_base;
	logic [SAMPLE_WIDTH-1:0] seed0;
	logic [SCALE_WIDTH-1:0] m_scale;
	int m_count;
	int m_pending;
	int ramp_batches;
	logic [BATCH_SAMPLES-1:0][SAMPLE_WIDTH-1:0] exp_batch;
	logic check_en;
	logic expect_quiet;
	logic stall_en;
	string test_name;
	int value_errors;
	int other_errors;
	int cycles;

	tb_clock_gen u_clock_gen (.ps_clk(ps_clk), .ps_rst(ps_rst));

	dac_interface #(
		.BATCH_SAMPLES(BATCH_SAMPLES),
		.SAMPLE_WIDTH(SAMPLE_WIDTH),
		.PWL_BATCHES(PWL_BATCHES)
	) u_dac_interface (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.fresh_bits(fresh_bits), .read_resps(read_resps),
		.scale_factor_in(scale_factor_in), .halt(halt), .dac0_rdy(dac0_rdy),
		.dac_batch(dac_batch), .valid_dac_batch(valid_dac_batch), .cfg_ready(cfg_ready));

	// triangle folds the upper half of the phase range back down
	function automatic logic [15:0] triangle(input logic [15:0] x);
		logic [14:0] part;
		part = x[15] ? ~x[14:0] : x[14:0];
		return {part, 1'b0};
	endfunction

	always @* begin
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			case (m_mode)
				1: exp_batch[i] = m_lfsr[i] >> m_scale;
				2: exp_batch[i] = triangle(m_phase + 16'(i)) >> m_scale;
				3: exp_batch[i] = (m_base + 16'(i)) >> m_scale;
				default: exp_batch[i] = '0;
			endcase
		end
	end

	// the model moves one batch forward for every batch the DUT delivers
	always @(posedge ps_clk) begin
		if (!ps_rst && valid_dac_batch) begin
			ramp_batches <= ramp_batches + 1;
			if (m_mode == 1) begin
				for (int i = 0; i < BATCH_SAMPLES; i++) begin
					m_lfsr[i] <= m_lfsr[i][0] ? ((m_lfsr[i] >> 1) ^ 16'hB400) : (m_lfsr[i] >> 1);
				end
			end else if (m_mode == 2) begin
				m_phase <= m_phase + 16'(BATCH_SAMPLES);
			end else if (m_mode == 3) begin
				m_base <= m_base + 16'(BATCH_SAMPLES);
				m_count <= m_count + 1;
				if (m_count == PWL_BATCHES - 1) begin
					if (m_pending > 0) begin
						m_pending <= m_pending - 1;
						m_base <= seed0;
						m_count <= 0;
					end else begin
						m_mode <= 0;
					end
				end
			end
		end
	end

	a_batch_value: assert property (@(posedge ps_clk) disable iff (ps_rst)
		(valid_dac_batch && check_en && m_mode != 0) |-> dac_batch == exp_batch)
		else begin
			value_errors++;
			$display("[ERROR] %s expected %h actual %h", test_name,
				$sampled(exp_batch), $sampled(dac_batch));
		end

	a_batch_expected: assert property (@(posedge ps_clk) disable iff (ps_rst)
		(valid_dac_batch && check_en) |-> m_mode != 0)
		else begin
			other_errors++;
			$display("%s: a batch appeared although none was due", test_name);
		end

	a_quiet: assert property (@(posedge ps_clk) disable iff (ps_rst)
		expect_quiet |-> !valid_dac_batch)
		else begin
			other_errors++;
			$display("%s: valid_dac_batch went high while the output should be idle", test_name);
		end

	always @(negedge ps_clk) begin
		dac0_rdy = stall_en ? ($urandom % 4 != 0) : 1'b1;
	end

	always @(posedge ps_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles in %s, the DUT stopped responding",
				cycles, test_name);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic strobe(input int idx);
		@(negedge ps_clk);
		fresh_bits[idx] = 1'b1;
		@(negedge ps_clk);
		fresh_bits = '0;
	endtask

	task automatic wait_ready();
		while (!cfg_ready) @(negedge ps_clk);
	endtask

	task automatic count_batches(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge ps_clk);
			if (valid_dac_batch) seen++;
		end
	endtask

	task automatic stop_output();
		check_en = 1'b0;
		@(negedge ps_clk);
		halt = 1'b1;
		repeat (3) @(negedge ps_clk);
		halt = 1'b0;
		@(negedge ps_clk);
		wait_ready();
		repeat (2) @(negedge ps_clk);
		m_mode <= 0;
		expect_quiet = 1'b1;
	endtask

	initial begin
		void'($urandom(53070));
		fresh_bits = '0;
		read_resps = '0;
		scale_factor_in = '0;
		halt = 1'b0;
		dac0_rdy = 1'b1;
		stall_en = 1'b0;
		check_en = 1'b0;
		expect_quiet = 1'b1;
		m_mode <= 0;
		m_scale = '0;
		m_pending <= 0;
		ramp_batches <= 0;
		value_errors = 0;
		other_errors = 0;
		cycles <= 0;

		test_name = "reset";
		@(negedge ps_clk);
		while (ps_rst) @(negedge ps_clk);
		wait_ready();
		repeat (10) @(negedge ps_clk);

		test_name = "noise";
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			read_resps[PS_SEED_BASE_ID+i] = $urandom;
			m_lfsr[i] <= (read_resps[PS_SEED_BASE_ID+i][15:0] == '0) ? 16'd1 :
				read_resps[PS_SEED_BASE_ID+i][15:0];
		end
		seed0 = read_resps[PS_SEED_BASE_ID][15:0];
		m_mode <= 1;
		expect_quiet = 1'b0;
		check_en = 1'b1;
		stall_en = 1'b1;
		strobe(PS_SEED_VALID_ID);
		wait_ready();
		count_batches(20);

		test_name = "scale";
		check_en = 1'b0;
		@(negedge ps_clk);
		scale_factor_in = 4'd3;
		m_scale = 4'd3;
		while (cfg_ready) @(negedge ps_clk);
		wait_ready();
		// the batch sitting in the scaler register as cfg_ready rises still has the old scale
		@(negedge ps_clk);
		check_en = 1'b1;
		count_batches(20);
		stop_output();

		test_name = "triangle";
		m_phase <= '0;
		m_mode <= 2;
		expect_quiet = 1'b0;
		check_en = 1'b1;
		strobe(TRIG_WAVE_ID);
		wait_ready();
		count_batches(16);
		stop_output();

		test_name = "ramp";
		m_base <= seed0;
		m_count <= 0;
		ramp_batches <= 0;
		m_mode <= 3;
		expect_quiet = 1'b0;
		check_en = 1'b1;
		strobe(RUN_PWL_ID);
		wait_ready();
		count_batches(3);
		m_pending <= 1;
		strobe(RUN_PWL_ID);
		while (m_mode != 0 || m_pending != 0) @(negedge ps_clk);
		expect_quiet = 1'b1;
		repeat (30) @(negedge ps_clk);
		if (ramp_batches != 2 * PWL_BATCHES) begin
			other_errors++;
			$display("%s: saw %0d batches instead of two full ramps", test_name,
				ramp_batches);
		end

		test_name = "halt";
		m_phase <= '0;
		m_mode <= 2;
		expect_quiet = 1'b0;
		check_en = 1'b1;
		strobe(TRIG_WAVE_ID);
		wait_ready();
		count_batches(6);
		stop_output();
		repeat (40) @(negedge ps_clk);

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- sources.f
dac_cfg_pkg.sv
dac_sample_pkg.sv
xfer_link.sv
dac_config_ctrl.sv
sample_generator.sv
batch_scaler.sv
dac_interface.sv
tb_clock_gen.sv
tb_dac_interface.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dac_interface -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi

if ! grep -q "All tests passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
